//--- bench/core_ctrl_tb.sv
// directed tests with expectations written per scenario; inputs idle with valid_fetch low so pc holds
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_tb;
    import pipe_ctrl_pkg::*;

    localparam int unsigned TEST_CYCLES   = 30;
    localparam int unsigned MARGIN_CYCLES = 20;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  valid_fetch_i;
    id_cu_t                id_cu_i;
    rr_cu_t                rr_cu_i;
    exe_cu_t               exe_cu_i;
    wb_cu_t                wb_cu_i;
    csr_cu_t               csr_cu_i;
    logic                  correct_branch_pred_i;
    logic                  debug_halt_i;
    logic                  debug_change_pc_i;
    logic                  debug_wr_valid_i;
    logic [XLEN-1:0]       decode_target_i;
    logic [XLEN-1:0]       exe_target_i;
    logic [XLEN-1:0]       csr_target_i;
    logic [XLEN-1:0]       debug_pc_i;
    reg_wr_t               commit_wr_i;
    reg_wr_t               debug_wr_i;
    logic [REG_ADDR_W-1:0] rs_addr_i;
    pipeline_ctrl_t        pipeline_ctrl_o;
    pipeline_flush_t       pipeline_flush_o;
    logic                  invalidate_icache_o;
    logic                  invalidate_buffer_o;
    logic [XLEN-1:0]       pc_o;
    logic [XLEN-1:0]       rs_data_o;

    logic [XLEN-1:0]       exp_pc;
    logic [REG_ADDR_W-1:0] rnd_addr;
    logic [XLEN-1:0]       rnd_data;
    int unsigned           checks;
    int unsigned           errors;

    core_ctrl_top core_ctrl_top_i (.*);

    always #50 clk_i = ~clk_i;

    // next drive point, 5 ns after the rising edge
    task tick;
        @(posedge clk_i);
        #5;
    endtask

    task check_value(input string test_name, input logic [31:0] expected,
                     input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    // if, id, rr, exe, wb from msb down
    function automatic logic [4:0] stall_vector();
        return {pipeline_ctrl_o.stall_if, pipeline_ctrl_o.stall_id, pipeline_ctrl_o.stall_rr,
                pipeline_ctrl_o.stall_exe, pipeline_ctrl_o.stall_wb};
    endfunction

    task clear_inputs;
        valid_fetch_i         = 1'b0;
        id_cu_i               = '0;
        rr_cu_i               = '0;
        exe_cu_i              = '0;
        wb_cu_i               = '0;
        csr_cu_i              = '0;
        correct_branch_pred_i = 1'b1;
        debug_halt_i          = 1'b0;
        debug_change_pc_i     = 1'b0;
        debug_wr_valid_i      = 1'b0;
        commit_wr_i           = '0;
        debug_wr_i            = '0;
    endtask

    task test_reset_fetch;
        #1;
        check_value("reset pc", BOOT_ADDR, pc_o);
        check_value("reset stalls", 32'b0, 32'(stall_vector()));
        check_value("reset flushes", 32'b0, 32'(pipeline_flush_o));
        check_value("reset invalidates", 32'b0, 32'({invalidate_icache_o, invalidate_buffer_o}));
        exp_pc        = BOOT_ADDR;
        valid_fetch_i = 1'b1;
        repeat (3) begin
            tick;
            exp_pc = exp_pc + 32'd4;
            check_value("sequential fetch", exp_pc, pc_o);
        end
        valid_fetch_i = 1'b0;
        tick;
        check_value("fetch hold", exp_pc, pc_o);
    endtask

    task test_mispredict_jal;
        clear_inputs;
        exe_cu_i.valid        = 1'b1;
        correct_branch_pred_i = 1'b0;
        exe_target_i          = 32'h0000_2000;
        #1;
        check_value("mispredict flush", 32'b11100, 32'(pipeline_flush_o));
        check_value("mispredict jump source", 32'(SEL_JUMP_EXECUTION),
                    32'(pipeline_ctrl_o.sel_addr_if));
        tick;
        check_value("mispredict pc", 32'h0000_2000, pc_o);
        // a stalled exe keeps rr alive
        exe_cu_i.stall = 1'b1;
        exe_target_i   = 32'h0000_2400;
        #1;
        check_value("stalled mispredict flush", 32'b11000, 32'(pipeline_flush_o));
        tick;
        check_value("stalled mispredict pc", 32'h0000_2400, pc_o);
        clear_inputs;
        id_cu_i.valid_jal = 1'b1;
        decode_target_i   = 32'h0000_3000;
        #1;
        check_value("jal flush", 32'b10000, 32'(pipeline_flush_o));
        tick;
        check_value("jal pc", 32'h0000_3000, pc_o);
        clear_inputs;
        exp_pc = 32'h0000_3000;
    endtask

    task test_exception;
        clear_inputs;
        rnd_addr             = 5'($urandom_range(31, 1));
        rnd_data             = $urandom;
        wb_cu_i.valid        = 1'b1;
        wb_cu_i.write_enable = 1'b1;
        commit_wr_i.addr     = rnd_addr;
        commit_wr_i.data     = rnd_data;
        tick;
        wb_cu_i.xcpt     = 1'b1;
        commit_wr_i.data = ~rnd_data;
        csr_target_i     = 32'h0000_4000;
        rs_addr_i        = rnd_addr;
        #1;
        check_value("exception flush", 32'b11110, 32'(pipeline_flush_o));
        tick;
        check_value("exception blocks commit", rnd_data, rs_data_o);
        check_value("exception pc hold", exp_pc, pc_o);
        // eret keeps a trigger present while the state is set
        clear_inputs;
        csr_cu_i.csr_eret = 1'b1;
        #1;
        check_value("exception state flush", 32'b11110, 32'(pipeline_flush_o));
        tick;
        check_value("exception pc", 32'h0000_4000, pc_o);
        #1;
        check_value("exception state one cycle", 32'b0, 32'(pipeline_flush_o));
        tick;
        // the held eret sets the state again once it has cleared
        clear_inputs;
        csr_target_i = 32'h0000_4400;
        #1;
        check_value("exception retrigger flush", 32'b11110, 32'(pipeline_flush_o));
        check_value("exception jump source", 32'(SEL_JUMP_CSR),
                    32'(pipeline_ctrl_o.sel_addr_if));
        tick;
        exp_pc = 32'h0000_4400;
        check_value("exception retrigger pc", exp_pc, pc_o);
    endtask

    task test_stalls_fence;
        clear_inputs;
        valid_fetch_i     = 1'b1;
        csr_cu_i.csr_stall = 1'b1;
        #1;
        check_value("csr stall", 32'b11110, 32'(stall_vector()));
        tick;
        check_value("csr stall pc", exp_pc, pc_o);
        clear_inputs;
        valid_fetch_i = 1'b1;
        wb_cu_i.valid = 1'b1;
        wb_cu_i.fence = 1'b1;
        #1;
        check_value("fence invalidates", 32'b11,
                    32'({invalidate_icache_o, invalidate_buffer_o}));
        check_value("fence flush", 32'b10000, 32'(pipeline_flush_o));
        tick;
        check_value("fence pc", exp_pc, pc_o);
        clear_inputs;
        valid_fetch_i           = 1'b1;
        wb_cu_i.valid           = 1'b1;
        wb_cu_i.stall_csr_fence = 1'b1;
        #1;
        check_value("wb csr stall", 32'b10000, 32'(stall_vector()));
        tick;
        check_value("wb csr stall pc", exp_pc, pc_o);
        clear_inputs;
    endtask

    task test_regfile_debug;
        clear_inputs;
        rnd_addr             = 5'($urandom_range(31, 1));
        rnd_data             = $urandom;
        wb_cu_i.valid        = 1'b1;
        wb_cu_i.write_enable = 1'b1;
        commit_wr_i.addr     = rnd_addr;
        commit_wr_i.data     = rnd_data;
        rs_addr_i            = rnd_addr;
        tick;
        check_value("commit write", rnd_data, rs_data_o);
        commit_wr_i.data       = ~rnd_data;
        csr_cu_i.csr_exception = 1'b1;
        csr_target_i           = 32'h0000_5000;
        tick;
        clear_inputs;
        #1;
        check_value("commit with csr exception", rnd_data, rs_data_o);
        // the csr exception redirects fetch one cycle later
        tick;
        exp_pc = 32'h0000_5000;
        check_value("csr exception pc", exp_pc, pc_o);
        wb_cu_i.valid        = 1'b1;
        wb_cu_i.write_enable = 1'b1;
        commit_wr_i.data     = $urandom | 32'd1;
        rs_addr_i            = '0;
        tick;
        check_value("x0 write", 32'b0, rs_data_o);
        clear_inputs;
        valid_fetch_i    = 1'b1;
        debug_halt_i     = 1'b1;
        debug_wr_valid_i = 1'b1;
        debug_wr_i.addr  = 5'($urandom_range(31, 1));
        debug_wr_i.data  = $urandom;
        rs_addr_i        = debug_wr_i.addr;
        tick;
        check_value("debug write", debug_wr_i.data, rs_data_o);
        check_value("halt pc hold", exp_pc, pc_o);
        debug_wr_valid_i  = 1'b0;
        debug_change_pc_i = 1'b1;
        debug_pc_i        = 32'h0000_8000;
        tick;
        check_value("debug pc", 32'h0000_8000, pc_o);
        clear_inputs;
    endtask

    initial begin
        void'($urandom(85));
        clk_i    = 1'b0;
        rstn_i   = 1'b0;
        checks   = 0;
        errors   = 0;
        clear_inputs;
        decode_target_i = '0;
        exe_target_i    = '0;
        csr_target_i    = '0;
        debug_pc_i      = '0;
        rs_addr_i       = '0;
        repeat (4) @(posedge clk_i);
        #5;
        rstn_i = 1'b1;
        test_reset_fetch;
        test_mispredict_jal;
        test_exception;
        test_stalls_fence;
        test_regfile_debug;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the test length
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * 100);
        $display("timeout: the tests did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hdl/pipe_ctrl_pkg.sv
hdl/control_unit.sv
hdl/fetch_pc_unit.sv
hdl/int_regfile.sv
hdl/core_ctrl_top.sv
bench/core_ctrl_tb.sv

//--- hdl/control_unit.sv
// outputs are combinational from inputs; exception state lasts one cycle and cannot retrigger back to back
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire logic                           clk_i,
    input  wire logic                           rstn_i,
    input  wire logic                           valid_fetch_i,
    input  wire pipe_ctrl_pkg::id_cu_t          id_cu_i,
    input  wire pipe_ctrl_pkg::rr_cu_t          rr_cu_i,
    input  wire pipe_ctrl_pkg::exe_cu_t         exe_cu_i,
    input  wire pipe_ctrl_pkg::wb_cu_t          wb_cu_i,
    input  wire pipe_ctrl_pkg::csr_cu_t         csr_cu_i,
    input  wire logic                           correct_branch_pred_i,
    input  wire logic                           debug_halt_i,
    input  wire logic                           debug_change_pc_i,
    input  wire logic                           debug_wr_valid_i,
    output pipe_ctrl_pkg::pipeline_ctrl_t       pipeline_ctrl_o,
    output pipe_ctrl_pkg::pipeline_flush_t      pipeline_flush_o,
    output pipe_ctrl_pkg::cu_if_t               cu_if_o,
    output pipe_ctrl_pkg::cu_rr_t               cu_rr_o,
    output logic                                invalidate_icache_o,
    output logic                                invalidate_buffer_o
);
    import pipe_ctrl_pkg::*;

    logic mispredict;
    logic jump_en;
    logic back_stall;
    logic stall_fetch;
    logic wb_fence;
    logic wb_csr_stall;
    logic wb_xcpt;
    logic any_csr_fence;
    logic debug_pc_req;
    logic debug_wr_req;
    logic xcpt_trigger;
    logic xcpt_state_q;

    assign mispredict    = exe_cu_i.valid && !correct_branch_pred_i;
    assign jump_en       = mispredict || id_cu_i.valid_jal;
    // csr or exe stall freezes everything up to exe
    assign back_stall    = csr_cu_i.csr_stall || exe_cu_i.stall;
    assign wb_fence      = wb_cu_i.valid && wb_cu_i.fence;
    assign wb_csr_stall  = wb_cu_i.valid && wb_cu_i.stall_csr_fence;
    assign wb_xcpt       = wb_cu_i.valid && wb_cu_i.xcpt;
    assign any_csr_fence = id_cu_i.stall_csr_fence || rr_cu_i.stall_csr_fence ||
                           exe_cu_i.stall_csr_fence || wb_cu_i.stall_csr_fence;
    assign debug_pc_req  = debug_halt_i && debug_change_pc_i;
    assign debug_wr_req  = debug_halt_i && debug_wr_valid_i;
    assign stall_fetch   = back_stall || wb_csr_stall;

    assign xcpt_trigger = wb_xcpt || csr_cu_i.csr_eret || csr_cu_i.csr_exception ||
                          (wb_cu_i.valid && wb_cu_i.ecall_taken);

    // held for a single cycle, the set cycle blocks a new set
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            xcpt_state_q <= 1'b0;
        end else begin
            xcpt_state_q <= !xcpt_state_q && xcpt_trigger;
        end
    end

    // stalls
    always_comb begin
        pipeline_ctrl_o.stall_if  = stall_fetch;
        pipeline_ctrl_o.stall_id  = back_stall;
        pipeline_ctrl_o.stall_rr  = back_stall;
        pipeline_ctrl_o.stall_exe = back_stall;
        pipeline_ctrl_o.stall_wb  = 1'b0;
    end

    // jump source, csr has priority over a mispredict
    always_comb begin
        if (xcpt_state_q) begin
            pipeline_ctrl_o.sel_addr_if = SEL_JUMP_CSR;
        end else if (mispredict) begin
            pipeline_ctrl_o.sel_addr_if = SEL_JUMP_EXECUTION;
        end else if (debug_pc_req) begin
            pipeline_ctrl_o.sel_addr_if = SEL_JUMP_DEBUG;
        end else begin
            pipeline_ctrl_o.sel_addr_if = SEL_JUMP_DECODE;
        end
    end

    // flushes
    always_comb begin
        pipeline_flush_o = '0;
        if (wb_xcpt || xcpt_state_q) begin
            pipeline_flush_o.flush_if  = 1'b1;
            pipeline_flush_o.flush_id  = 1'b1;
            pipeline_flush_o.flush_rr  = 1'b1;
            pipeline_flush_o.flush_exe = 1'b1;
        end else if (mispredict) begin
            pipeline_flush_o.flush_if = 1'b1;
            pipeline_flush_o.flush_id = 1'b1;
            // a stalled exe still holds the branch, keep rr
            pipeline_flush_o.flush_rr = !exe_cu_i.stall;
        end else if ((any_csr_fence || id_cu_i.valid_jal || wb_fence) && !back_stall) begin
            pipeline_flush_o.flush_if = 1'b1;
        end
    end

    // next pc
    always_comb begin
        if (debug_pc_req) begin
            cu_if_o.next_pc = NEXT_PC_SEL_DEBUG;
        end else if (jump_en || xcpt_state_q) begin
            cu_if_o.next_pc = NEXT_PC_SEL_JUMP;
        end else if (!valid_fetch_i || stall_fetch || any_csr_fence || wb_fence ||
                     debug_halt_i) begin
            cu_if_o.next_pc = NEXT_PC_SEL_KEEP_PC;
        end else begin
            cu_if_o.next_pc = NEXT_PC_SEL_BP_OR_PC_4;
        end
    end

    // commit write, debug writes only while halted
    always_comb begin
        cu_rr_o.sel_debug    = debug_wr_req;
        cu_rr_o.write_enable = debug_wr_req ||
                               (wb_cu_i.valid && wb_cu_i.write_enable &&
                                !wb_cu_i.xcpt && !csr_cu_i.csr_exception);
    end

    // a fence may follow self-modifying code
    assign invalidate_icache_o = wb_fence;
    assign invalidate_buffer_o = wb_cu_i.valid &&
                                 (wb_cu_i.fence || xcpt_state_q || wb_cu_i.stall_csr_fence);

endmodule

`default_nettype wire

//--- hdl/core_ctrl_top.sv
// decode, exe, csr and cache live outside; their status and targets arrive as plain inputs
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_top (
    input  wire logic                                 clk_i,
    input  wire logic                                 rstn_i,
    input  wire logic                                 valid_fetch_i,
    input  wire pipe_ctrl_pkg::id_cu_t                id_cu_i,
    input  wire pipe_ctrl_pkg::rr_cu_t                rr_cu_i,
    input  wire pipe_ctrl_pkg::exe_cu_t               exe_cu_i,
    input  wire pipe_ctrl_pkg::wb_cu_t                wb_cu_i,
    input  wire pipe_ctrl_pkg::csr_cu_t               csr_cu_i,
    input  wire logic                                 correct_branch_pred_i,
    input  wire logic                                 debug_halt_i,
    input  wire logic                                 debug_change_pc_i,
    input  wire logic                                 debug_wr_valid_i,
    input  wire logic [pipe_ctrl_pkg::XLEN-1:0]       decode_target_i,
    input  wire logic [pipe_ctrl_pkg::XLEN-1:0]       exe_target_i,
    input  wire logic [pipe_ctrl_pkg::XLEN-1:0]       csr_target_i,
    input  wire logic [pipe_ctrl_pkg::XLEN-1:0]       debug_pc_i,
    input  wire pipe_ctrl_pkg::reg_wr_t               commit_wr_i,
    input  wire pipe_ctrl_pkg::reg_wr_t               debug_wr_i,
    input  wire logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] rs_addr_i,
    output pipe_ctrl_pkg::pipeline_ctrl_t             pipeline_ctrl_o,
    output pipe_ctrl_pkg::pipeline_flush_t            pipeline_flush_o,
    output logic                                      invalidate_icache_o,
    output logic                                      invalidate_buffer_o,
    output logic      [pipe_ctrl_pkg::XLEN-1:0]       pc_o,
    output logic      [pipe_ctrl_pkg::XLEN-1:0]       rs_data_o
);
    import pipe_ctrl_pkg::*;

    cu_if_t cu_if;
    cu_rr_t cu_rr;

    control_unit control_unit_i (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .valid_fetch_i         (valid_fetch_i),
        .id_cu_i               (id_cu_i),
        .rr_cu_i               (rr_cu_i),
        .exe_cu_i              (exe_cu_i),
        .wb_cu_i               (wb_cu_i),
        .csr_cu_i              (csr_cu_i),
        .correct_branch_pred_i (correct_branch_pred_i),
        .debug_halt_i          (debug_halt_i),
        .debug_change_pc_i     (debug_change_pc_i),
        .debug_wr_valid_i      (debug_wr_valid_i),
        .pipeline_ctrl_o       (pipeline_ctrl_o),
        .pipeline_flush_o      (pipeline_flush_o),
        .cu_if_o               (cu_if),
        .cu_rr_o               (cu_rr),
        .invalidate_icache_o   (invalidate_icache_o),
        .invalidate_buffer_o   (invalidate_buffer_o)
    );

    // jump source travels inside the stall record
    fetch_pc_unit fetch_pc_unit_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .cu_if_i         (cu_if),
        .sel_addr_if_i   (pipeline_ctrl_o.sel_addr_if),
        .decode_target_i (decode_target_i),
        .exe_target_i    (exe_target_i),
        .csr_target_i    (csr_target_i),
        .debug_pc_i      (debug_pc_i),
        .pc_o            (pc_o)
    );

    int_regfile int_regfile_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cu_rr_i     (cu_rr),
        .commit_wr_i (commit_wr_i),
        .debug_wr_i  (debug_wr_i),
        .rs_addr_i   (rs_addr_i),
        .rs_data_o   (rs_data_o)
    );

endmodule

`default_nettype wire

//--- hdl/fetch_pc_unit.sv
// pc updates one cycle after the selection is presented; only the bp-or-pc4 choice increments by 4
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit (
    input  wire logic                              clk_i,
    input  wire logic                              rstn_i,
    input  wire pipe_ctrl_pkg::cu_if_t             cu_if_i,
    input  wire pipe_ctrl_pkg::sel_addr_if_t       sel_addr_if_i,
    input  wire logic [pipe_ctrl_pkg::XLEN-1:0]    decode_target_i,
    input  wire logic [pipe_ctrl_pkg::XLEN-1:0]    exe_target_i,
    input  wire logic [pipe_ctrl_pkg::XLEN-1:0]    csr_target_i,
    input  wire logic [pipe_ctrl_pkg::XLEN-1:0]    debug_pc_i,
    output logic      [pipe_ctrl_pkg::XLEN-1:0]    pc_o
);
    import pipe_ctrl_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic [XLEN-1:0] jump_target;

    // pick the jump target
    always_comb begin
        case (sel_addr_if_i)
            SEL_JUMP_DECODE: begin
                jump_target = decode_target_i;
            end
            SEL_JUMP_EXECUTION: begin
                jump_target = exe_target_i;
            end
            SEL_JUMP_CSR: begin
                jump_target = csr_target_i;
            end
            SEL_JUMP_DEBUG: begin
                jump_target = debug_pc_i;
            end
        endcase
    end

    // next address
    always_comb begin
        case (cu_if_i.next_pc)
            NEXT_PC_SEL_BP_OR_PC_4: begin
                pc_d = pc_q + XLEN'(4);
            end
            NEXT_PC_SEL_KEEP_PC: begin
                pc_d = pc_q;
            end
            NEXT_PC_SEL_JUMP: begin
                pc_d = jump_target;
            end
            NEXT_PC_SEL_DEBUG: begin
                pc_d = debug_pc_i;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= BOOT_ADDR;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- hdl/int_regfile.sv
// one write port shared by commit and debug, one combinational read port; x0 always reads zero
`timescale 1ns/1ps
`default_nettype none

module int_regfile (
    input  wire logic                                 clk_i,
    input  wire logic                                 rstn_i,
    input  wire pipe_ctrl_pkg::cu_rr_t                cu_rr_i,
    input  wire pipe_ctrl_pkg::reg_wr_t               commit_wr_i,
    input  wire pipe_ctrl_pkg::reg_wr_t               debug_wr_i,
    input  wire logic [pipe_ctrl_pkg::REG_ADDR_W-1:0] rs_addr_i,
    output logic      [pipe_ctrl_pkg::XLEN-1:0]       rs_data_o
);
    import pipe_ctrl_pkg::*;

    logic [XLEN-1:0] regs_q [NUM_REGS];
    reg_wr_t         wr_sel;

    // debug record wins when the control unit selects it
    assign wr_sel = cu_rr_i.sel_debug ? debug_wr_i : commit_wr_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (cu_rr_i.write_enable && (wr_sel.addr != '0)) begin
            regs_q[wr_sel.addr] <= wr_sel.data;
        end
    end

    // x0 keeps its reset value since writes to it are dropped
    assign rs_data_o = regs_q[rs_addr_i];

endmodule

`default_nettype wire

//--- hdl/pipe_ctrl_pkg.sv
// shared widths, select encodings and status records; encodings must match the decode/exe/csr side
`default_nettype none

package pipe_ctrl_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 32;

    // pc value taken out of reset
    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_1000;

    // fetch next-pc choice, no predictor so bp means pc+4
    typedef enum logic [1:0] {
        NEXT_PC_SEL_BP_OR_PC_4 = 2'b00,
        NEXT_PC_SEL_KEEP_PC    = 2'b01,
        NEXT_PC_SEL_JUMP       = 2'b10,
        NEXT_PC_SEL_DEBUG      = 2'b11
    } next_pc_sel_t;

    // where a jump target comes from
    typedef enum logic [1:0] {
        SEL_JUMP_DECODE    = 2'b00,
        SEL_JUMP_EXECUTION = 2'b01,
        SEL_JUMP_CSR       = 2'b10,
        SEL_JUMP_DEBUG     = 2'b11
    } sel_addr_if_t;

    // stage status towards the control unit
    typedef struct packed {
        logic valid_jal;
        logic stall_csr_fence;
    } id_cu_t;

    typedef struct packed {
        logic stall_csr_fence;
    } rr_cu_t;

    typedef struct packed {
        logic valid;
        logic stall;
        logic stall_csr_fence;
    } exe_cu_t;

    typedef struct packed {
        logic valid;
        logic xcpt;
        logic ecall_taken;
        logic fence;
        logic write_enable;
        logic stall_csr_fence;
    } wb_cu_t;

    typedef struct packed {
        logic csr_eret;
        logic csr_exception;
        logic csr_stall;
    } csr_cu_t;

    // control unit decisions
    typedef struct packed {
        logic         stall_if;
        logic         stall_id;
        logic         stall_rr;
        logic         stall_exe;
        logic         stall_wb;
        sel_addr_if_t sel_addr_if;
    } pipeline_ctrl_t;

    typedef struct packed {
        logic flush_if;
        logic flush_id;
        logic flush_rr;
        logic flush_exe;
        logic flush_wb;
    } pipeline_flush_t;

    typedef struct packed {
        next_pc_sel_t next_pc;
    } cu_if_t;

    // sel_debug picks the debug record as write source
    typedef struct packed {
        logic write_enable;
        logic sel_debug;
    } cu_rr_t;

    // one register write, used for commit and debug
    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } reg_wr_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the core control testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module core_ctrl_tb -o core_ctrl_sim
./obj_dir/core_ctrl_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
